// File: verilog.f
+incdir+verilog
verilog/decodePkg.sv
verilog/registerFile.sv
verilog/immediateGen.sv
verilog/controlDecoder.sv
verilog/decodeStage.sv
tests/decodeStageTb.sv

// File: tests/decodeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module decodeStageTb;

	localparam int RESET_CYCLES = 16;
	localparam int IDLE_COUNT = 20;
	localparam int REG_WRITES = 31;
	localparam int OP_COUNT = 200;
	localparam int FORMAT_COUNT = 300;
	localparam int BYPASS_COUNT = 40;
	localparam int HOLD_CYCLES = 30;
	localparam int UNLISTED_COUNT = 64;
	localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_COUNT + REG_WRITES + OP_COUNT
		+ FORMAT_COUNT + BYPASS_COUNT + HOLD_CYCLES + UNLISTED_COUNT + 10;
	localparam longint WATCHDOG_NS = 2 * TOTAL_CYCLES * 20;

	typedef struct packed {
		logic [`XLEN-1:0] pcOut;
		logic [`XLEN-1:0] readData1;
		logic [`XLEN-1:0] readData2;
		logic [`XLEN-1:0] imm;
		logic [`ALU_CTRL_W-1:0] aluControl;
		logic [`BRANCH_TYPE_W-1:0] branchType;
		logic [`LOAD_TYPE_W-1:0] loadType;
		logic [`STORE_TYPE_W-1:0] storeType;
		logic [`REG_INDEX_W-1:0] destRegister;
		logic [`REG_INDEX_W-1:0] registerRs;
		logic [`REG_INDEX_W-1:0] registerRt;
		logic branch;
		logic jump;
		logic jalr;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic memOrReg;
	} decodeResult;

	logic clk;
	logic reset;
	logic [`XLEN-1:0] pc;
	decodePkg::instrWord instr;
	logic wbWrite;
	logic [`REG_INDEX_W-1:0] wbRegister;
	logic [`XLEN-1:0] wbData;
	logic hold;
	logic squash;
	logic [`XLEN-1:0] pcOut;
	logic [`XLEN-1:0] readData1;
	logic [`XLEN-1:0] readData2;
	logic [`XLEN-1:0] imm;
	logic [`ALU_CTRL_W-1:0] aluControl;
	logic [`BRANCH_TYPE_W-1:0] branchType;
	logic [`LOAD_TYPE_W-1:0] loadType;
	logic [`STORE_TYPE_W-1:0] storeType;
	logic [`REG_INDEX_W-1:0] destRegister;
	logic [`REG_INDEX_W-1:0] registerRs;
	logic [`REG_INDEX_W-1:0] registerRt;
	logic branch;
	logic jump;
	logic jalr;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic memOrReg;

	logic [`XLEN-1:0] modelRegs [0:31];
	decodeResult expected;
	integer seed = 32'h0373bea9;
	int checkCount = 0;
	int errorCount = 0;
	int testStartErrors = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	decodeStage decodeStage_inst (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.wbWrite(wbWrite),
		.wbRegister(wbRegister),
		.wbData(wbData),
		.hold(hold),
		.squash(squash),
		.pcOut(pcOut),
		.readData1(readData1),
		.readData2(readData2),
		.imm(imm),
		.aluControl(aluControl),
		.branchType(branchType),
		.loadType(loadType),
		.storeType(storeType),
		.destRegister(destRegister),
		.registerRs(registerRs),
		.registerRt(registerRt),
		.branch(branch),
		.jump(jump),
		.jalr(jalr),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.memOrReg(memOrReg)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	// register read as the decode stage sees it, with same-cycle write-back
	function automatic logic [`XLEN-1:0] readModel(input logic [`REG_INDEX_W-1:0] index,
			input logic wbW, input logic [`REG_INDEX_W-1:0] wbR, input logic [`XLEN-1:0] wbD);
		if (index == 0)
			return '0;
		if (wbW && wbR == index)
			return wbD;
		return modelRegs[index];
	endfunction

	function automatic decodeResult expectDecode(input logic [31:0] word,
			input logic [`XLEN-1:0] pcIn, input logic wbW,
			input logic [`REG_INDEX_W-1:0] wbR, input logic [`XLEN-1:0] wbD);
		decodeResult e;
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [`XLEN-1:0] iImm;
		logic useRs;
		logic takePc;
		e = '0;
		opc = word[6:0];
		f7 = word[31:25];
		f3 = word[14:12];
		iImm = {{52{word[31]}}, word[31:20]};
		useRs = 1'b0;
		takePc = 1'b0;
		e.pcOut = pcIn;
		case (opc)
			`OPC_LUI, `OPC_AUIPC: begin
				e.regWrite = 1'b1;
				e.destRegister = word[11:7];
				e.imm = {{32{word[31]}}, word[31:12], 12'b0};
				if (opc == `OPC_AUIPC) begin
					takePc = 1'b1;
					e.aluControl = `ALU_ADD;
				end
			end
			`OPC_JAL: begin
				e.jump = 1'b1;
				e.regWrite = 1'b1;
				e.destRegister = word[11:7];
				e.imm = {{44{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
			end
			`OPC_JALR: begin
				e.jump = 1'b1;
				e.jalr = 1'b1;
				e.regWrite = 1'b1;
				e.destRegister = word[11:7];
				e.registerRs = word[19:15];
				useRs = 1'b1;
				e.imm = iImm;
			end
			`OPC_BRANCH: begin
				e.branch = 1'b1;
				e.registerRs = word[19:15];
				e.registerRt = word[24:20];
				useRs = 1'b1;
				e.imm = {{52{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
				case (f3)
					3'b000: e.branchType = `BR_EQ;
					3'b001: e.branchType = `BR_NE;
					3'b100: e.branchType = `BR_LT;
					3'b101: e.branchType = `BR_GE;
					3'b110: e.branchType = `BR_LTU;
					3'b111: e.branchType = `BR_GEU;
					default: e.branchType = '0;
				endcase
			end
			`OPC_LOAD: begin
				e.memRead = 1'b1;
				e.regWrite = 1'b1;
				e.memOrReg = 1'b1;
				e.destRegister = word[11:7];
				e.registerRs = word[19:15];
				useRs = 1'b1;
				e.imm = iImm;
				e.aluControl = (f3 == 3'b111) ? 6'd0 : `ALU_ADD;
				case (f3)
					3'b000: e.loadType = `LD_B;
					3'b001: e.loadType = `LD_H;
					3'b010: e.loadType = `LD_W;
					3'b011: e.loadType = `LD_D;
					3'b100: e.loadType = `LD_BU;
					3'b101: e.loadType = `LD_HU;
					3'b110: e.loadType = `LD_WU;
					default: e.loadType = '0;
				endcase
			end
			`OPC_STORE: begin
				e.memWrite = 1'b1;
				e.registerRs = word[19:15];
				e.registerRt = word[24:20];
				useRs = 1'b1;
				e.imm = {{52{word[31]}}, word[31:25], word[11:7]};
				e.aluControl = f3[2] ? 6'd0 : `ALU_ADD;
				case (f3)
					3'b000: e.storeType = `ST_B;
					3'b001: e.storeType = `ST_H;
					3'b010: e.storeType = `ST_W;
					3'b011: e.storeType = `ST_D;
					default: e.storeType = '0;
				endcase
			end
			`OPC_OPIMM, `OPC_OPIMM32: begin
				e.regWrite = 1'b1;
				e.destRegister = word[11:7];
				e.registerRs = word[19:15];
				useRs = 1'b1;
				e.imm = iImm;
				if (opc == `OPC_OPIMM) begin
					case (f3)
						3'b000: e.aluControl = `ALU_ADD;
						3'b010: e.aluControl = `ALU_SLTI;
						3'b011: e.aluControl = `ALU_SLTIU;
						3'b100: e.aluControl = `ALU_XORI;
						3'b110: e.aluControl = `ALU_ORI;
						3'b111: e.aluControl = `ALU_ANDI;
						3'b001: e.aluControl = (word[31:26] == 6'h00) ? `ALU_SLLI : 6'd0;
						default: begin
							if (word[31:26] == 6'h00)
								e.aluControl = `ALU_SRLI;
							else if (word[31:26] == 6'h10)
								e.aluControl = `ALU_SRAI;
						end
					endcase
				end else begin
					if (f3 == 3'b000)
						e.aluControl = `ALU_ADDIW; // upper bits are immediate
					else if (f3 == 3'b001 && f7 == 7'h00)
						e.aluControl = `ALU_SLLIW;
					else if (f3 == 3'b101 && f7 == 7'h00)
						e.aluControl = `ALU_SRLIW;
					else if (f3 == 3'b101 && f7 == 7'h20)
						e.aluControl = `ALU_SRAIW;
				end
			end
			`OPC_OP, `OPC_OP32: begin
				e.regWrite = 1'b1;
				e.destRegister = word[11:7];
				e.registerRs = word[19:15];
				e.registerRt = word[24:20];
				useRs = 1'b1;
				if (opc == `OPC_OP) begin
					if (f7 == 7'h01)
						e.aluControl = `ALU_MUL + f3; // m codes run in funct3 order
					else if (f7 == 7'h00) begin
						case (f3)
							3'b000: e.aluControl = `ALU_ADDR;
							3'b001: e.aluControl = `ALU_SLL;
							3'b010: e.aluControl = `ALU_SLT;
							3'b011: e.aluControl = `ALU_SLTU;
							3'b100: e.aluControl = `ALU_XOR;
							3'b101: e.aluControl = `ALU_SRL;
							3'b110: e.aluControl = `ALU_OR;
							default: e.aluControl = `ALU_AND;
						endcase
					end else if (f7 == 7'h20 && f3 == 3'b000)
						e.aluControl = `ALU_SUB;
					else if (f7 == 7'h20 && f3 == 3'b101)
						e.aluControl = `ALU_SRA;
				end else begin
					if (f7 == 7'h00 && f3 == 3'b000)
						e.aluControl = `ALU_ADDW;
					else if (f7 == 7'h00 && f3 == 3'b001)
						e.aluControl = `ALU_SLLW;
					else if (f7 == 7'h00 && f3 == 3'b101)
						e.aluControl = `ALU_SRLW;
					else if (f7 == 7'h20 && f3 == 3'b000)
						e.aluControl = `ALU_SUBW;
					else if (f7 == 7'h20 && f3 == 3'b101)
						e.aluControl = `ALU_SRAW;
					else if (f7 == 7'h01 && f3 == 3'b000)
						e.aluControl = `ALU_MULW;
					else if (f7 == 7'h01 && f3[2])
						e.aluControl = `ALU_DIVW + f3 - 3'd4;
				end
			end
			default: ; // not decoded, only pc passes
		endcase
		if (takePc)
			e.readData1 = pcIn;
		else if (useRs)
			e.readData1 = readModel(e.registerRs, wbW, wbR, wbD);
		e.readData2 = readModel(e.registerRt, wbW, wbR, wbD);
		return e;
	endfunction

	task automatic checkWord(input string name, input logic [`XLEN-1:0] exp,
			input logic [`XLEN-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic checkCode(input string name, input logic [`ALU_CTRL_W-1:0] exp,
			input logic [`ALU_CTRL_W-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic compareOutputs(input decodeResult e);
		checkWord("pcOut", e.pcOut, pcOut);
		checkWord("readData1", e.readData1, readData1);
		checkWord("readData2", e.readData2, readData2);
		checkWord("imm", e.imm, imm);
		checkCode("aluControl", e.aluControl, aluControl);
		checkCode("branchType", e.branchType, branchType);
		checkCode("loadType", e.loadType, loadType);
		checkCode("storeType", e.storeType, storeType);
		checkCode("destRegister", e.destRegister, destRegister);
		checkCode("registerRs", e.registerRs, registerRs);
		checkCode("registerRt", e.registerRt, registerRt);
		checkFlag("branch", e.branch, branch);
		checkFlag("jump", e.jump, jump);
		checkFlag("jalr", e.jalr, jalr);
		checkFlag("memRead", e.memRead, memRead);
		checkFlag("memWrite", e.memWrite, memWrite);
		checkFlag("regWrite", e.regWrite, regWrite);
		checkFlag("memOrReg", e.memOrReg, memOrReg);
	endtask

	// inputs only move 2 ns after the edge, so sampling at the edge is safe
	initial begin
		expected = '0;
		forever begin
			@(posedge clk);
			if (reset) begin
				expected = '0;
				for (int r = 0; r < 32; r++)
					modelRegs[r] = '0;
			end else if (!hold) begin
				if (squash)
					expected = '0;
				else
					expected = expectDecode(instr, pc, wbWrite, wbRegister, wbData);
				if (wbWrite && wbRegister != 0)
					modelRegs[wbRegister] = wbData;
			end
			#1;
			compareOutputs(expected);
		end
	end

	task automatic driveCycle(input logic [31:0] word, input logic [`XLEN-1:0] pcIn,
			input logic wbW, input logic [`REG_INDEX_W-1:0] wbR, input logic [`XLEN-1:0] wbD,
			input logic holdIn, input logic squashIn);
		@(posedge clk);
		#2;
		instr = word;
		pc = pcIn;
		wbWrite = wbW;
		wbRegister = wbR;
		wbData = wbD;
		hold = holdIn;
		squash = squashIn;
	endtask

	function automatic logic [`XLEN-1:0] randomDouble();
		return {$random(seed), $random(seed)};
	endfunction

	// random OP or OP-32 word, funct7 biased to the listed values
	function automatic logic [31:0] randomOp();
		logic [31:0] word;
		logic [31:0] coin;
		word = $random(seed);
		coin = $random(seed);
		case (coin[1:0])
			2'd0: word[31:25] = 7'h00;
			2'd1: word[31:25] = 7'h20;
			default: word[31:25] = 7'h01;
		endcase
		word[6:0] = coin[2] ? `OPC_OP32 : `OPC_OP;
		return word;
	endfunction

	function automatic logic [31:0] randomFormat();
		logic [31:0] word;
		logic [31:0] coin;
		word = $random(seed);
		coin = $random(seed);
		case ($unsigned(coin[15:0]) % 9)
			0: word[6:0] = `OPC_LUI;
			1: word[6:0] = `OPC_AUIPC;
			2: word[6:0] = `OPC_JAL;
			3: word[6:0] = `OPC_JALR;
			4: word[6:0] = `OPC_BRANCH;
			5: word[6:0] = `OPC_LOAD;
			6: word[6:0] = `OPC_STORE;
			7: word[6:0] = `OPC_OPIMM;
			default: word[6:0] = `OPC_OPIMM32;
		endcase
		// steer shift encodings onto the listed funct values
		if (word[6:0] == `OPC_OPIMM && word[13:12] == 2'b01)
			word[31:26] = coin[20] ? 6'h10 : 6'h00;
		if (word[6:0] == `OPC_OPIMM32 && word[13:12] == 2'b01)
			word[31:25] = coin[20] ? 7'h20 : 7'h00;
		return word;
	endfunction

	function automatic logic [31:0] unlistedWord(input int kind);
		logic [31:0] word;
		logic [31:0] coin;
		word = $random(seed);
		coin = $random(seed);
		case (kind)
			0: word[6:0] = coin[0] ? 7'b0001111 : (coin[1] ? 7'b1110011 : 7'b1111111);
			1: word = {7'h7f, word[24:7], `OPC_OP};
			2: word = {7'h20, word[24:15], 3'b001, word[11:7], `OPC_OP};
			3: word = {7'h00, word[24:15], 3'b010, word[11:7], `OPC_OP32};
			4: word = {word[31:15], 3'b010, word[11:7], `OPC_OPIMM32};
			5: word = {word[31:15], 3'b111, word[11:7], `OPC_LOAD};
			6: word = {word[31:15], 1'b1, word[13:7], `OPC_STORE};
			default: word = {6'h3f, word[25:15], 3'b001, word[11:7], `OPC_OPIMM};
		endcase
		return word;
	endfunction

	task automatic issue(input logic [31:0] word);
		driveCycle(word, randomDouble(), 1'b0, '0, '0, 1'b0, 1'b0);
	endtask

	task automatic finishTest(input int number, input string name);
		if (errorCount == testStartErrors) begin
			testsPassed++;
			$display("test %0d %s: passed", number, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: failed with %0d mismatches", number, name,
				errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	initial begin
		logic [31:0] word;
		logic [`REG_INDEX_W-1:0] index;
		logic [`XLEN-1:0] data;
		logic [`XLEN-1:0] heldPc;
		reset = 1'b1;
		pc = '0;
		instr = '0;
		wbWrite = 1'b0;
		wbRegister = '0;
		wbData = '0;
		hold = 1'b0;
		squash = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;

		for (int i = 0; i < IDLE_COUNT; i++)
			issue(randomOp()); // every register still zero
		finishTest(1, "reset state");

		for (int r = 1; r <= REG_WRITES; r++)
			driveCycle(32'h0, randomDouble(), 1'b1, r[4:0], randomDouble(), 1'b0, 1'b0);
		for (int i = 0; i < OP_COUNT; i++) begin
			word = $random(seed);
			driveCycle(randomOp(), randomDouble(), word[0], word[12:8], randomDouble(),
				1'b0, 1'b0);
		end
		finishTest(2, "op and op-32 decode");

		for (int i = 0; i < FORMAT_COUNT; i++)
			issue(randomFormat());
		finishTest(3, "immediate formats and control");

		for (int i = 0; i < BYPASS_COUNT; i++) begin
			word = $random(seed);
			index = (i % 8 == 0) ? 5'd0 : word[4:0];
			data = randomDouble();
			word = {7'h00, word[9] ? word[24:20] : index, index, 3'b000, word[11:7], `OPC_OP};
			driveCycle(word, randomDouble(), 1'b1, index, data, 1'b0, 1'b0);
		end
		finishTest(4, "write-back bypass");

		for (int i = 0; i < 5; i++)
			driveCycle(randomFormat(), randomDouble(), 1'b0, '0, '0, 1'b0, 1'b1);
		for (int i = 0; i < 3; i++)
			issue(randomOp());
		heldPc = randomDouble();
		driveCycle({7'h00, 5'd5, 5'd5, 3'b000, 5'd9, `OPC_OP}, heldPc, 1'b0, '0, '0,
			1'b0, 1'b0);
		for (int i = 0; i < 6; i++) begin
			// write-back to x5 must be dropped while frozen
			driveCycle(randomFormat(), randomDouble(), 1'b1, 5'd5, randomDouble(),
				1'b1, i == 3);
		end
		issue({7'h00, 5'd5, 5'd5, 3'b000, 5'd9, `OPC_OP});
		issue(randomOp());
		finishTest(5, "squash and hold");

		for (int i = 0; i < UNLISTED_COUNT; i++)
			issue(unlistedWord(i % 8));
		finishTest(6, "unknown opcode and funct");

		driveCycle(32'h0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
		@(posedge clk);
		#5;
		$display("tests passed %0d, tests failed %0d, checks %0d, mismatches %0d",
			testsPassed, testsFailed, checkCount, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module decodeStage (
	input wire clk,
	input wire reset,
	input wire [`XLEN-1:0] pc,
	input wire decodePkg::instrWord instr,
	input wire wbWrite,
	input wire [`REG_INDEX_W-1:0] wbRegister,
	input wire [`XLEN-1:0] wbData,
	input wire hold,
	input wire squash,
	output logic [`XLEN-1:0] pcOut,
	output logic [`XLEN-1:0] readData1,
	output logic [`XLEN-1:0] readData2,
	output logic [`XLEN-1:0] imm,
	output logic [`ALU_CTRL_W-1:0] aluControl,
	output logic [`BRANCH_TYPE_W-1:0] branchType,
	output logic [`LOAD_TYPE_W-1:0] loadType,
	output logic [`STORE_TYPE_W-1:0] storeType,
	output logic [`REG_INDEX_W-1:0] destRegister,
	output logic [`REG_INDEX_W-1:0] registerRs,
	output logic [`REG_INDEX_W-1:0] registerRt,
	output logic branch,
	output logic jump,
	output logic jalr,
	output logic memRead,
	output logic memWrite,
	output logic regWrite,
	output logic memOrReg
);

	logic [`XLEN-1:0] rfData1;
	logic [`XLEN-1:0] rfData2;
	logic [`XLEN-1:0] nextImm;
	logic [`XLEN-1:0] operand1;
	logic [`ALU_CTRL_W-1:0] nextAluControl;
	logic [`BRANCH_TYPE_W-1:0] nextBranchType;
	logic [`LOAD_TYPE_W-1:0] nextLoadType;
	logic [`STORE_TYPE_W-1:0] nextStoreType;
	logic [`REG_INDEX_W-1:0] nextDest;
	logic [`REG_INDEX_W-1:0] nextRs;
	logic [`REG_INDEX_W-1:0] nextRt;
	logic nextBranch;
	logic nextJump;
	logic nextJalr;
	logic nextMemRead;
	logic nextMemWrite;
	logic nextRegWrite;
	logic nextMemOrReg;
	logic useRs1;
	logic usePc;
	logic clearStage;

	controlDecoder decoder (
		.instr(instr),
		.branch(nextBranch),
		.jump(nextJump),
		.jalr(nextJalr),
		.memRead(nextMemRead),
		.memWrite(nextMemWrite),
		.regWrite(nextRegWrite),
		.memOrReg(nextMemOrReg),
		.aluControl(nextAluControl),
		.branchType(nextBranchType),
		.loadType(nextLoadType),
		.storeType(nextStoreType),
		.destRegister(nextDest),
		.registerRs(nextRs),
		.registerRt(nextRt),
		.useRs1(useRs1),
		.usePc(usePc)
	);

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.wbWrite(wbWrite),
		.wbRegister(wbRegister),
		.wbData(wbData),
		.readIndex1(nextRs),
		.readIndex2(nextRt),
		.readData1(rfData1),
		.readData2(rfData2)
	);

	immediateGen immGen (
		.instr(instr),
		.imm(nextImm)
	);

	// operand 1 is pc for auipc, zero for lui/jal
	assign operand1 = usePc ? pc : (useRs1 ? rfData1 : '0);

	// hold wins over squash
	assign clearStage = reset | (squash & ~hold);

	always_ff @(posedge clk) begin
		if (clearStage) begin
			pcOut <= '0;
			readData1 <= '0;
			readData2 <= '0;
			imm <= '0;
			aluControl <= '0;
			branchType <= '0;
			loadType <= '0;
			storeType <= '0;
			destRegister <= '0;
			registerRs <= '0;
			registerRt <= '0;
			branch <= 1'b0;
			jump <= 1'b0;
			jalr <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			regWrite <= 1'b0;
			memOrReg <= 1'b0;
		end else if (!hold) begin
			pcOut <= pc;
			readData1 <= operand1;
			readData2 <= rfData2; // zero when rs2 unused, index 0
			imm <= nextImm;
			aluControl <= nextAluControl;
			branchType <= nextBranchType;
			loadType <= nextLoadType;
			storeType <= nextStoreType;
			destRegister <= nextDest;
			registerRs <= nextRs;
			registerRt <= nextRt;
			branch <= nextBranch;
			jump <= nextJump;
			jalr <= nextJalr;
			memRead <= nextMemRead;
			memWrite <= nextMemWrite;
			regWrite <= nextRegWrite;
			memOrReg <= nextMemOrReg;
		end
	end

endmodule

`default_nettype wire

// File: verilog/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module controlDecoder (
	input wire decodePkg::instrWord instr,
	output logic branch,
	output logic jump,
	output logic jalr,
	output logic memRead,
	output logic memWrite,
	output logic regWrite,
	output logic memOrReg,
	output logic [`ALU_CTRL_W-1:0] aluControl,
	output logic [`BRANCH_TYPE_W-1:0] branchType,
	output logic [`LOAD_TYPE_W-1:0] loadType,
	output logic [`STORE_TYPE_W-1:0] storeType,
	output logic [`REG_INDEX_W-1:0] destRegister,
	output logic [`REG_INDEX_W-1:0] registerRs,
	output logic [`REG_INDEX_W-1:0] registerRt,
	output logic useRs1,
	output logic usePc
);

	always_comb begin
		branch = 1'b0;
		jump = 1'b0;
		jalr = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		memOrReg = 1'b0;
		aluControl = '0;
		branchType = '0;
		loadType = '0;
		storeType = '0;
		destRegister = '0;
		registerRs = '0;
		registerRt = '0;
		useRs1 = 1'b0;
		usePc = 1'b0;

		case (instr.r.opcode)
			`OPC_LUI: begin
				regWrite = 1'b1; // operand 1 stays zero
				destRegister = instr.u.rd;
			end
			`OPC_AUIPC: begin
				regWrite = 1'b1;
				destRegister = instr.u.rd;
				usePc = 1'b1;
				aluControl = `ALU_ADD;
			end
			`OPC_JAL: begin
				jump = 1'b1;
				regWrite = 1'b1;
				destRegister = instr.j.rd;
			end
			`OPC_JALR: begin
				jump = 1'b1;
				jalr = 1'b1;
				regWrite = 1'b1;
				destRegister = instr.i.rd;
				registerRs = instr.i.rs1;
				useRs1 = 1'b1;
			end
			`OPC_BRANCH: begin
				branch = 1'b1;
				registerRs = instr.b.rs1;
				registerRt = instr.b.rs2;
				useRs1 = 1'b1;
				case (instr.b.funct3)
					3'b000: branchType = `BR_EQ;
					3'b001: branchType = `BR_NE;
					3'b100: branchType = `BR_LT;
					3'b101: branchType = `BR_GE;
					3'b110: branchType = `BR_LTU;
					3'b111: branchType = `BR_GEU;
					default: branchType = '0;
				endcase
			end
			`OPC_LOAD: begin
				memRead = 1'b1;
				regWrite = 1'b1;
				memOrReg = 1'b1; // result comes from memory
				destRegister = instr.i.rd;
				registerRs = instr.i.rs1;
				useRs1 = 1'b1;
				aluControl = `ALU_ADD;
				case (instr.i.funct3)
					3'b000: loadType = `LD_B;
					3'b001: loadType = `LD_H;
					3'b010: loadType = `LD_W;
					3'b011: loadType = `LD_D;
					3'b100: loadType = `LD_BU;
					3'b101: loadType = `LD_HU;
					3'b110: loadType = `LD_WU;
					default: aluControl = '0;
				endcase
			end
			`OPC_STORE: begin
				memWrite = 1'b1;
				registerRs = instr.s.rs1;
				registerRt = instr.s.rs2;
				useRs1 = 1'b1;
				aluControl = `ALU_ADD;
				case (instr.s.funct3)
					3'b000: storeType = `ST_B;
					3'b001: storeType = `ST_H;
					3'b010: storeType = `ST_W;
					3'b011: storeType = `ST_D;
					default: aluControl = '0;
				endcase
			end
			`OPC_OPIMM: begin
				regWrite = 1'b1;
				destRegister = instr.i.rd;
				registerRs = instr.i.rs1;
				useRs1 = 1'b1;
				case (instr.i.funct3)
					3'b000: aluControl = `ALU_ADD;
					3'b010: aluControl = `ALU_SLTI;
					3'b011: aluControl = `ALU_SLTIU;
					3'b100: aluControl = `ALU_XORI;
					3'b110: aluControl = `ALU_ORI;
					3'b111: aluControl = `ALU_ANDI;
					3'b001: begin
						if (instr.i.imm[11:6] == `F6_LOGIC)
							aluControl = `ALU_SLLI;
					end
					default: begin // 101, shift right picked by funct6
						if (instr.i.imm[11:6] == `F6_LOGIC)
							aluControl = `ALU_SRLI;
						else if (instr.i.imm[11:6] == `F6_ARITH)
							aluControl = `ALU_SRAI;
					end
				endcase
			end
			`OPC_OPIMM32: begin
				regWrite = 1'b1;
				destRegister = instr.i.rd;
				registerRs = instr.i.rs1;
				useRs1 = 1'b1;
				case ({instr.r.funct7, instr.i.funct3})
					{`F7_BASE, 3'b001}: aluControl = `ALU_SLLIW;
					{`F7_BASE, 3'b101}: aluControl = `ALU_SRLIW;
					{`F7_ALT, 3'b101}: aluControl = `ALU_SRAIW;
					default: begin
						if (instr.i.funct3 == 3'b000)
							aluControl = `ALU_ADDIW; // funct7 is immediate here
					end
				endcase
			end
			`OPC_OP: begin
				regWrite = 1'b1;
				destRegister = instr.r.rd;
				registerRs = instr.r.rs1;
				registerRt = instr.r.rs2;
				useRs1 = 1'b1;
				case ({instr.r.funct7, instr.r.funct3})
					{`F7_BASE, 3'b000}: aluControl = `ALU_ADDR;
					{`F7_ALT, 3'b000}: aluControl = `ALU_SUB;
					{`F7_BASE, 3'b001}: aluControl = `ALU_SLL;
					{`F7_BASE, 3'b010}: aluControl = `ALU_SLT;
					{`F7_BASE, 3'b011}: aluControl = `ALU_SLTU;
					{`F7_BASE, 3'b100}: aluControl = `ALU_XOR;
					{`F7_BASE, 3'b101}: aluControl = `ALU_SRL;
					{`F7_ALT, 3'b101}: aluControl = `ALU_SRA;
					{`F7_BASE, 3'b110}: aluControl = `ALU_OR;
					{`F7_BASE, 3'b111}: aluControl = `ALU_AND;
					{`F7_MULDIV, 3'b000}: aluControl = `ALU_MUL;
					{`F7_MULDIV, 3'b001}: aluControl = `ALU_MULH;
					{`F7_MULDIV, 3'b010}: aluControl = `ALU_MULHSU;
					{`F7_MULDIV, 3'b011}: aluControl = `ALU_MULHU;
					{`F7_MULDIV, 3'b100}: aluControl = `ALU_DIV;
					{`F7_MULDIV, 3'b101}: aluControl = `ALU_DIVU;
					{`F7_MULDIV, 3'b110}: aluControl = `ALU_REM;
					{`F7_MULDIV, 3'b111}: aluControl = `ALU_REMU;
					default: aluControl = '0;
				endcase
			end
			`OPC_OP32: begin
				regWrite = 1'b1;
				destRegister = instr.r.rd;
				registerRs = instr.r.rs1;
				registerRt = instr.r.rs2;
				useRs1 = 1'b1;
				case ({instr.r.funct7, instr.r.funct3})
					{`F7_BASE, 3'b000}: aluControl = `ALU_ADDW;
					{`F7_ALT, 3'b000}: aluControl = `ALU_SUBW;
					{`F7_BASE, 3'b001}: aluControl = `ALU_SLLW;
					{`F7_BASE, 3'b101}: aluControl = `ALU_SRLW;
					{`F7_ALT, 3'b101}: aluControl = `ALU_SRAW;
					{`F7_MULDIV, 3'b000}: aluControl = `ALU_MULW;
					{`F7_MULDIV, 3'b100}: aluControl = `ALU_DIVW;
					{`F7_MULDIV, 3'b101}: aluControl = `ALU_DIVUW;
					{`F7_MULDIV, 3'b110}: aluControl = `ALU_REMW;
					{`F7_MULDIV, 3'b111}: aluControl = `ALU_REMUW;
					default: aluControl = '0;
				endcase
			end
			default: ; // unknown opcode, all zero
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/immediateGen.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module immediateGen (
	input wire decodePkg::instrWord instr,
	output logic [`XLEN-1:0] imm
);

	always_comb begin
		case (instr.i.opcode)
			`OPC_JALR, `OPC_LOAD, `OPC_OPIMM, `OPC_OPIMM32:
				imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
			`OPC_STORE:
				imm = {{(`XLEN-12){instr.s.immHigh[6]}}, instr.s.immHigh, instr.s.immLow};
			`OPC_BRANCH: begin
				imm = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.immMid,
					instr.b.immLow, 1'b0};
			end
			`OPC_LUI, `OPC_AUIPC:
				imm = {{(`XLEN-32){instr.u.imm[19]}}, instr.u.imm, 12'b0}; // upper 20 bits
			`OPC_JAL: begin
				imm = {{(`XLEN-20){instr.j.imm20}}, instr.j.immHigh, instr.j.imm11,
					instr.j.immLow, 1'b0};
			end
			default:
				imm = '0; // OP, OP-32 and unknown
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_consts.svh"

module registerFile (
	input wire clk,
	input wire reset,
	input wire hold,
	input wire wbWrite,
	input wire [`REG_INDEX_W-1:0] wbRegister,
	input wire [`XLEN-1:0] wbData,
	input wire [`REG_INDEX_W-1:0] readIndex1,
	input wire [`REG_INDEX_W-1:0] readIndex2,
	output logic [`XLEN-1:0] readData1,
	output logic [`XLEN-1:0] readData2
);

	logic [`XLEN-1:0] regs [1:31]; // x0 not stored
	logic writeEnable;

	assign writeEnable = wbWrite & ~hold & (wbRegister != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 1; r < 32; r++) begin
				regs[r] <= '0;
			end
		end else if (writeEnable) begin
			regs[wbRegister] <= wbData;
		end
	end

	// write-through so a same-cycle write-back is seen by decode
	assign readData1 = (readIndex1 == '0) ? '0
		: (writeEnable && wbRegister == readIndex1) ? wbData : regs[readIndex1];
	assign readData2 = (readIndex2 == '0) ? '0
		: (writeEnable && wbRegister == readIndex2) ? wbData : regs[readIndex2];

endmodule

`default_nettype wire

// File: verilog/decodePkg.sv
`default_nettype none

`include "decode_consts.svh"

package decodePkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_INDEX_W-1:0] rs2;
		logic [`REG_INDEX_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_INDEX_W-1:0] rd;
		logic [6:0] opcode;
	} rFormat;

	typedef struct packed {
		logic [11:0] imm; // funct6 of shifts sits in imm[11:6]
		logic [`REG_INDEX_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_INDEX_W-1:0] rd;
		logic [6:0] opcode;
	} iFormat;

	typedef struct packed {
		logic [6:0] immHigh;
		logic [`REG_INDEX_W-1:0] rs2;
		logic [`REG_INDEX_W-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLow;
		logic [6:0] opcode;
	} sFormat;

	typedef struct packed {
		logic imm12;
		logic [5:0] immMid; // imm[10:5]
		logic [`REG_INDEX_W-1:0] rs2;
		logic [`REG_INDEX_W-1:0] rs1;
		logic [2:0] funct3;
		logic [3:0] immLow; // imm[4:1]
		logic imm11;
		logic [6:0] opcode;
	} bFormat;

	typedef struct packed {
		logic [19:0] imm;
		logic [`REG_INDEX_W-1:0] rd;
		logic [6:0] opcode;
	} uFormat;

	typedef struct packed {
		logic imm20;
		logic [9:0] immLow; // imm[10:1]
		logic imm11;
		logic [7:0] immHigh; // imm[19:12]
		logic [`REG_INDEX_W-1:0] rd;
		logic [6:0] opcode;
	} jFormat;

	// one fetched word, read as whichever format the opcode picks
	typedef union packed {
		rFormat r;
		iFormat i;
		sFormat s;
		bFormat b;
		uFormat u;
		jFormat j;
	} instrWord;

endpackage

`default_nettype wire

// File: verilog/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define XLEN 64
`define REG_INDEX_W 5
`define ALU_CTRL_W 6
`define BRANCH_TYPE_W 3
`define LOAD_TYPE_W 3
`define STORE_TYPE_W 2

// major opcodes
`define OPC_LUI 7'b0110111
`define OPC_AUIPC 7'b0010111
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011
`define OPC_OPIMM 7'b0010011
`define OPC_OP 7'b0110011
`define OPC_OPIMM32 7'b0011011
`define OPC_OP32 7'b0111011

`define F7_BASE 7'b0000000
`define F7_ALT 7'b0100000
`define F7_MULDIV 7'b0000001
`define F6_LOGIC 6'b000000 // rv64 shift-immediate upper bits
`define F6_ARITH 6'b010000

// alu codes, zero means no alu operation
`define ALU_ADD 6'd1 // addi, also address add for loads/stores
`define ALU_SLTI 6'd2
`define ALU_SLTIU 6'd3
`define ALU_XORI 6'd4
`define ALU_ORI 6'd5
`define ALU_ANDI 6'd6
`define ALU_SLLI 6'd7
`define ALU_SRLI 6'd8
`define ALU_SRAI 6'd9
`define ALU_ADDR 6'd12 // register-register add
`define ALU_SUB 6'd13
`define ALU_SLL 6'd14
`define ALU_SLT 6'd15
`define ALU_SLTU 6'd16
`define ALU_XOR 6'd17
`define ALU_SRL 6'd18
`define ALU_SRA 6'd19
`define ALU_OR 6'd20
`define ALU_AND 6'd21
`define ALU_ADDIW 6'd22
`define ALU_SLLIW 6'd23
`define ALU_SRLIW 6'd24
`define ALU_SRAIW 6'd25
`define ALU_ADDW 6'd26
`define ALU_SUBW 6'd27
`define ALU_SLLW 6'd28
`define ALU_SRLW 6'd29
`define ALU_SRAW 6'd30
`define ALU_MUL 6'd31
`define ALU_MULH 6'd32
`define ALU_MULHSU 6'd33
`define ALU_MULHU 6'd34
`define ALU_DIV 6'd35
`define ALU_DIVU 6'd36
`define ALU_REM 6'd37
`define ALU_REMU 6'd38
`define ALU_MULW 6'd39
`define ALU_DIVW 6'd40
`define ALU_DIVUW 6'd41
`define ALU_REMW 6'd42
`define ALU_REMUW 6'd43

`define BR_EQ 3'd2
`define BR_NE 3'd3
`define BR_LT 3'd4
`define BR_GE 3'd5
`define BR_LTU 3'd6
`define BR_GEU 3'd7

`define LD_D 3'd0
`define LD_B 3'd1
`define LD_H 3'd2
`define LD_W 3'd3
`define LD_BU 3'd4
`define LD_HU 3'd5
`define LD_WU 3'd6

`define ST_D 2'd0
`define ST_W 2'd1
`define ST_H 2'd2
`define ST_B 2'd3

`endif
